// File: Makefile
TOP = sift_core_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
verilog/sift_pkg.sv
verilog/sift_ifs.sv
verilog/frame_mem.sv
verilog/line_buffer.sv
verilog/gauss_blur.sv
verilog/keypoint_detect.sv
verilog/sift_core.sv
dv/sift_core_asserts.sv
dv/sift_core_tb.sv

// File: dv/sift_core_asserts.sv
`timescale 1ns/100ps

module sift_core_asserts (
  input logic       clk,
  input logic       rst_n,
  input logic       out_valid,
  input logic       done,
  input logic       kp_we,
  input logic [7:0] kp_count,
  input logic       blur_valid,
  input logic       busy
);
  import sift_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_out_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(out_valid && done)) else $error("out_valid and done high in the same cycle");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done) else $error("done held for more than one cycle");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Detector
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_kp_room: assert property (@(posedge clk) disable iff (!rst_n)
    kp_we |-> (kp_count < 8'(KP_DEPTH))) else $error("Keypoint write beyond memory depth");

  a_busy_follows: assert property (@(posedge clk) disable iff (!rst_n)
    blur_valid |=> busy) else $error("Detector not busy after a blurred row");

endmodule

bind sift_core sift_core_asserts u_sift_core_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .out_valid  (out_valid),
  .done       (done),
  .kp_we      (kp_we),
  .kp_count   (kp_count),
  .blur_valid (u_blur_if.blur_valid),
  .busy       (busy)
);

// File: dv/sift_core_tb.sv
`timescale 1ns/100ps

module sift_core_tb;
  import sift_pkg::*;

  localparam int TIMEOUT_CYCLES = 5000;
  localparam int THRESH         = DOG_THRESH_DEFAULT;
  localparam int IMG_RANDOM     = 0;
  localparam int IMG_FLAT       = 1;
  localparam int IMG_CHECKER    = 2;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic [15:0] in_data;
  logic        out_valid;
  logic [15:0] out_data;
  logic        done;

  logic [PIX_W-1:0] img [IMG_H][IMG_W];
  logic [15:0]      exp_q [$];          // Expected keypoints of the current frame
  int               k3 [3] = '{1, 2, 1};
  int               k5 [5] = '{1, 4, 6, 4, 1};
  int               seed;
  int               rcv_cnt = 0;
  int               base_cnt;

  sift_core sift_core_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data),
    .done      (done)
  );

  always #50 clk = ~clk;

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run aborted");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic void ref_keypoints();
    int s3;
    int s5;
    int dog;
    exp_q.delete();
    for (int r = BORDER; r < IMG_H - BORDER; r++) begin
      for (int c = BORDER; c < IMG_W - BORDER; c++) begin
        s3 = 0;
        s5 = 0;
        for (int i = 0; i < 5; i++) begin
          for (int j = 0; j < 5; j++) begin
            s5 += k5[i] * k5[j] * int'(img[r+i-2][c+j-2]);
            if (i >= 1 && i <= 3 && j >= 1 && j <= 3) begin
              s3 += k3[i-1] * k3[j-1] * int'(img[r+i-2][c+j-2]);
            end
          end
        end
        dog = s5 / 256 - s3 / 16;       // Both sums are positive, so this truncates
        if (dog < 0) begin
          dog = -dog;
        end
        if (dog >= THRESH) begin
          exp_q.push_back({8'(r), 8'(c)});
        end
      end
    end
  endfunction

  task automatic fill_image(input int kind);
    for (int r = 0; r < IMG_H; r++) begin
      for (int c = 0; c < IMG_W; c++) begin
        case (kind)
          IMG_RANDOM: img[r][c] = 8'($random(seed));
          IMG_FLAT:   img[r][c] = 8'h5a;
          default:    img[r][c] = ((r / 3 + c / 3) % 2 == 0) ? 8'he0 : 8'h20;
        endcase
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus and waiting
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic load_image(input bit gaps);
    int gap;
    for (int r = 0; r < IMG_H; r++) begin
      for (int w = 0; w < WORDS_PER_ROW; w++) begin
        gap = 0;
        while (gaps && gap < 4 && ($random(seed) & 3) == 0) begin
          @(posedge clk);
          in_valid <= 1'b0;
          gap++;
        end
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= {img[r][2*w+1], img[r][2*w]};   // Left pixel in the low byte
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_done(input string label);
    int   cycles;
    logic prev_valid;
    cycles     = 0;
    prev_valid = 1'b0;
    while (done !== 1'b1) begin
      if (prev_valid === 1'b1 && out_valid !== 1'b1) begin
        abort_run("out_valid dropped without done in the next cycle");
      end
      prev_valid = out_valid;
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        abort_run($sformatf("Timeout, done never arrived for the %s frame", label));
      end
    end
    // With keypoints, done comes right after the last out_valid
    check_equal("out_valid before done", 32'(prev_valid), 32'(exp_q.size() > 0));
  endtask

  task automatic run_frame(input string label, input int kind, input bit gaps);
    fill_image(kind);
    ref_keypoints();
    base_cnt = rcv_cnt;
    load_image(gaps);
    wait_done(label);
    check_equal("keypoint count", 32'(rcv_cnt - base_cnt), 32'(exp_q.size()));
    $display("Frame %s done with %0d keypoints", label, exp_q.size());
  endtask

  // Output monitor
  always @(posedge clk) begin
    if (rst_n === 1'b1 && out_valid === 1'b1) begin
      if (rcv_cnt - base_cnt >= exp_q.size()) begin
        abort_run("More keypoints came out than the reference predicts");
      end else begin
        check_equal("out_data", 32'(out_data), 32'(exp_q[rcv_cnt - base_cnt]));
      end
      rcv_cnt++;
    end
  end

  initial begin
    seed     = 32'h7f00acbd;
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    base_cnt = 0;
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    check_equal("out_valid", 32'(out_valid), 32'h0);
    check_equal("done", 32'(done), 32'h0);
    @(posedge clk);
    rst_n <= 1'b1;                      // Third reset cycle ends here
    @(negedge clk);
    check_equal("out_valid", 32'(out_valid), 32'h0);
    check_equal("done", 32'(done), 32'h0);

    run_frame("random", IMG_RANDOM, 1'b0);
    run_frame("flat", IMG_FLAT, 1'b0);
    run_frame("gapped random", IMG_RANDOM, 1'b1);
    run_frame("checkerboard", IMG_CHECKER, 1'b0);
    run_frame("back to back random", IMG_RANDOM, 1'b0);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog/frame_mem.sv
`timescale 1ns/100ps

module frame_mem #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 128
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic [WIDTH-1:0]         din,
  output logic [WIDTH-1:0]         dout
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];                  // Old data on a write cycle
  end

endmodule

// File: verilog/gauss_blur.sv
`timescale 1ns/100ps

module gauss_blur #(
  parameter int KSIZE = 5
) (
  input  logic                         clk,
  input  logic                         rst_n,
  row_window_if.snk                    win,
  output logic                         out_valid,
  output logic [sift_pkg::COORD_W-1:0] out_row_idx,
  output logic [sift_pkg::ROW_W-1:0]   out_row
);
  import sift_pkg::*;

  localparam int HALF    = KSIZE / 2;
  localparam int ROW_OFF = 2 - HALF;          // 3x3 uses window rows 1 to 3
  localparam int SHIFT   = 2 * (KSIZE - 1);   // Kernel sum is 16 or 256
  localparam int ACC_W   = PIX_W + SHIFT;

  logic [ROW_W-1:0] blur_row;
  logic [ACC_W-1:0] acc;

  // Binomial taps are 1 2 1 or 1 4 6 4 1
  function automatic int unsigned tap(input int idx);
    int unsigned w;
    if (KSIZE == 3) begin
      w = (idx == 1) ? 2 : 1;
    end else begin
      case (idx)
        0, 4:    w = 1;
        1, 3:    w = 4;
        default: w = 6;
      endcase
    end
    return w;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // All interior columns in parallel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    blur_row = '0;
    acc      = '0;
    for (int c = BORDER; c < IMG_W - BORDER; c++) begin
      acc = '0;
      for (int dy = 0; dy < KSIZE; dy++) begin
        for (int dx = 0; dx < KSIZE; dx++) begin
          acc = acc + ACC_W'(tap(dy) * tap(dx) *
                             win.rows[ROW_OFF+dy][(c+dx-HALF)*PIX_W +: PIX_W]);
        end
      end
      blur_row[c*PIX_W +: PIX_W] = acc[SHIFT +: PIX_W];   // Truncating divide
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= win.win_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (win.win_valid) begin
      out_row     <= blur_row;
      out_row_idx <= win.center_row;
    end
  end

endmodule

// File: verilog/keypoint_detect.sv
`timescale 1ns/100ps

module keypoint_detect #(
  parameter int THRESH = 4
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  blur_row_if.snk                               blur,
  input  logic                                  frame_start,
  output logic                                  busy,
  output logic                                  kp_we,
  output logic [$clog2(sift_pkg::KP_DEPTH)-1:0] kp_addr,
  output logic [15:0]                           kp_din,
  output logic [7:0]                            kp_count
);
  import sift_pkg::*;

  localparam int COL_FIRST = BORDER;
  localparam int COL_LAST  = IMG_W - BORDER - 1;

  logic [ROW_W-1:0]   b3_q;
  logic [ROW_W-1:0]   b5_q;
  logic [COORD_W-1:0] row_q;
  logic [COORD_W-1:0] col;
  logic [PIX_W-1:0]   p3;
  logic [PIX_W-1:0]   p5;
  logic signed [PIX_W:0] dog;
  logic [PIX_W:0]     dog_abs;
  logic               start;
  logic               hit;

  assign start = blur.blur_valid && !busy;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // DoG test at the current column
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign p3      = b3_q[col*PIX_W +: PIX_W];
  assign p5      = b5_q[col*PIX_W +: PIX_W];
  assign dog     = $signed({1'b0, p5}) - $signed({1'b0, p3});   // blur5 minus blur3
  assign dog_abs = (dog < 0) ? $unsigned(-dog) : $unsigned(dog);
  assign hit     = busy && (dog_abs >= (PIX_W + 1)'(THRESH));

  assign kp_we   = hit;
  assign kp_addr = kp_count;
  assign kp_din  = {row_q, col};        // Row in the high byte

  always_ff @(posedge clk) begin
    if (start) begin
      b3_q  <= blur.blur3;
      b5_q  <= blur.blur5;
      row_q <= blur.row_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      col      <= '0;
      kp_count <= '0;
    end else begin
      if (start) begin
        busy <= 1'b1;
        col  <= COORD_W'(COL_FIRST);
      end else if (busy) begin
        col <= col + 1'b1;
        if (col == COORD_W'(COL_LAST)) begin
          busy <= 1'b0;                 // Twelve columns scanned
        end
      end

      if (frame_start) begin
        kp_count <= '0;
      end else if (hit) begin
        kp_count <= kp_count + 1'b1;    // Raster order follows the scan
      end
    end
  end

endmodule

// File: verilog/line_buffer.sv
`timescale 1ns/100ps

module line_buffer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       shift,
  input  logic [sift_pkg::ROW_W-1:0] row_in,
  input  logic                       frame_start,
  row_window_if.src                  win
);
  import sift_pkg::*;

  localparam int NROWS = 5;

  logic [COORD_W-1:0] row_cnt;          // Rows received in this frame
  logic               full;

  assign full = (row_cnt >= COORD_W'(NROWS - 1));

  // The newest row enters at the bottom and older rows move up
  always_ff @(posedge clk) begin
    if (shift) begin
      for (int i = 0; i < NROWS - 1; i++) begin
        win.rows[i] <= win.rows[i+1];
      end
      win.rows[NROWS-1] <= row_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_cnt        <= '0;
      win.win_valid  <= 1'b0;
      win.center_row <= '0;
    end else begin
      win.win_valid <= shift && full;
      if (shift && full) begin
        win.center_row <= row_cnt - COORD_W'(BORDER);   // Incoming row minus two
      end
      if (frame_start) begin
        row_cnt <= '0;
      end else if (shift) begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

endmodule

// File: verilog/sift_core.sv
`timescale 1ns/100ps

module sift_core #(
  parameter int DOG_THRESH = sift_pkg::DOG_THRESH_DEFAULT
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  logic [15:0] in_data,
  output logic        out_valid,
  output logic [15:0] out_data,
  output logic        done
);
  import sift_pkg::*;

  localparam int WORD_W  = 2 * PIX_W;
  localparam int WD_AW   = $clog2(WORDS_PER_ROW);
  localparam int LD_AW   = $clog2(IMG_H * WORDS_PER_ROW);
  localparam int LD_LAST = IMG_H * WORDS_PER_ROW - 1;
  localparam int IMG_AW  = $clog2(IMG_H);
  localparam int KP_AW   = $clog2(KP_DEPTH);
  localparam int KP_W    = 2 * COORD_W;

  core_state_t state;
  core_state_t state_next;

  logic              accept;
  logic              frame_start;
  logic [LD_AW-1:0]  ld_cnt;
  logic [ROW_W-1:0]  row_buf;
  logic              img_we;
  logic [IMG_AW-1:0] img_addr;
  logic [ROW_W-1:0]  img_din;
  logic [ROW_W-1:0]  img_dout;
  logic [IMG_AW-1:0] rd_row;
  logic              rd_en;
  logic              shift_q;
  logic              in_flight;
  logic              busy;
  logic              kp_we;
  logic [KP_AW-1:0]  kp_addr;
  logic [KP_AW-1:0]  kp_mem_addr;
  logic [KP_AW-1:0]  dump_cnt;
  logic [KP_W-1:0]   kp_din;
  logic [KP_W-1:0]   kp_dout;
  logic [7:0]        kp_count;
  logic              dump_rd;

  row_window_if u_win_if ();
  blur_row_if   u_blur_if ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Word packer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign accept      = in_valid && (state == ST_IDLE || state == ST_LOAD);
  assign frame_start = in_valid && (state == ST_IDLE);
  assign img_we      = accept && (ld_cnt[WD_AW-1:0] == WD_AW'(WORDS_PER_ROW - 1));
  assign img_din     = {in_data, row_buf[ROW_W-WORD_W-1:0]};   // Last word lands on top
  assign img_addr    = (state == ST_BLUR) ? rd_row : ld_cnt[LD_AW-1:WD_AW];

  always_ff @(posedge clk) begin
    if (accept) begin
      row_buf[ld_cnt[WD_AW-1:0]*WORD_W +: WORD_W] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ld_cnt <= '0;
    end else if (accept) begin
      ld_cnt <= (ld_cnt == LD_AW'(LD_LAST)) ? '0 : ld_cnt + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Row streaming
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // A row is in flight from its read until the detector picks it up
  assign in_flight = shift_q || u_win_if.win_valid || u_blur_if.blur_valid;
  assign rd_en     = (state == ST_BLUR) && !in_flight && !busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_row  <= '0;
      shift_q <= 1'b0;
    end else begin
      shift_q <= rd_en;                 // Read data is valid one cycle later
      if (state == ST_IDLE) begin
        rd_row <= '0;
      end else if (rd_en) begin
        rd_row <= rd_row + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Keypoint dump
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign dump_rd     = (state == ST_DUMP) && (dump_cnt != kp_count);
  assign kp_mem_addr = (state == ST_DUMP) ? dump_cnt : kp_addr;
  assign out_data    = kp_dout;
  assign done        = (state == ST_DONE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dump_cnt  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= dump_rd;
      if (state != ST_DUMP) begin
        dump_cnt <= '0;
      end else if (dump_rd) begin
        dump_cnt <= dump_cnt + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Phase FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE:        if (accept) state_next = ST_LOAD;
      ST_LOAD:        if (accept && ld_cnt == LD_AW'(LD_LAST)) state_next = ST_BLUR;
      ST_BLUR:        if (rd_en && rd_row == IMG_AW'(IMG_H - 1)) state_next = ST_DETECT_WAIT;
      ST_DETECT_WAIT: if (!in_flight && !busy) state_next = ST_DUMP;
      ST_DUMP:        if (dump_cnt == kp_count) state_next = ST_DONE;
      ST_DONE:        state_next = ST_IDLE;
      default:        state_next = ST_IDLE;
    endcase
  end

  frame_mem #(.DEPTH(IMG_H), .WIDTH(ROW_W)) img_mem (
    .clk  (clk),
    .we   (img_we),
    .addr (img_addr),
    .din  (img_din),
    .dout (img_dout)
  );

  frame_mem #(.DEPTH(KP_DEPTH), .WIDTH(KP_W)) kp_mem (
    .clk  (clk),
    .we   (kp_we),
    .addr (kp_mem_addr),
    .din  (kp_din),
    .dout (kp_dout)
  );

  line_buffer u_line_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .shift       (shift_q),
    .row_in      (img_dout),
    .frame_start (frame_start),
    .win         (u_win_if.src)
  );

  gauss_blur #(.KSIZE(3)) g_blur_3x3 (
    .clk         (clk),
    .rst_n       (rst_n),
    .win         (u_win_if.snk),
    .out_valid   (),
    .out_row_idx (),
    .out_row     (u_blur_if.blur3)
  );

  gauss_blur #(.KSIZE(5)) g_blur_5x5 (
    .clk         (clk),
    .rst_n       (rst_n),
    .win         (u_win_if.snk),
    .out_valid   (u_blur_if.blur_valid),
    .out_row_idx (u_blur_if.row_idx),
    .out_row     (u_blur_if.blur5)
  );

  keypoint_detect #(.THRESH(DOG_THRESH)) u_keypoint_detect (
    .clk         (clk),
    .rst_n       (rst_n),
    .blur        (u_blur_if.snk),
    .frame_start (frame_start),
    .busy        (busy),
    .kp_we       (kp_we),
    .kp_addr     (kp_addr),
    .kp_din      (kp_din),
    .kp_count    (kp_count)
  );

endmodule

// File: verilog/sift_ifs.sv
`timescale 1ns/100ps

interface row_window_if;
  import sift_pkg::*;

  logic               win_valid;        // One cycle per new window
  logic [COORD_W-1:0] center_row;
  logic [ROW_W-1:0]   rows [5];         // Index 0 is the oldest row, 2 the center

  modport src (
    output win_valid,
    output center_row,
    output rows
  );

  modport snk (
    input win_valid,
    input center_row,
    input rows
  );
endinterface

interface blur_row_if;
  import sift_pkg::*;

  logic               blur_valid;
  logic [COORD_W-1:0] row_idx;
  logic [ROW_W-1:0]   blur3;
  logic [ROW_W-1:0]   blur5;

  modport src3 (output blur3);
  modport src5 (output blur_valid, output row_idx, output blur5);
  modport snk  (input blur_valid, input row_idx, input blur3, input blur5);
endinterface

// File: verilog/sift_pkg.sv
package sift_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Image geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int IMG_W         = 16;
  localparam int IMG_H         = 16;
  localparam int PIX_W         = 8;
  localparam int ROW_W         = IMG_W * PIX_W;    // One image row per memory word
  localparam int WORDS_PER_ROW = IMG_W / 2;        // Two pixels per input word
  localparam int BORDER        = 2;                // No full 5x5 window at the edge

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Keypoint storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int KP_DEPTH           = (IMG_W - 2 * BORDER) * (IMG_H - 2 * BORDER);
  localparam int COORD_W            = 8;           // Keypoint word is {row, col}
  localparam int DOG_THRESH_DEFAULT = 4;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_BLUR,
    ST_DETECT_WAIT,
    ST_DUMP,
    ST_DONE
  } core_state_t;

endpackage
